/* verilog.f */
ddr3_wr_pkg.sv
wr_burst_decode.sv
ddr3_write_datapath.sv
ddr3_write_shift.sv
ddr3_wr_top.sv
tb_wr_monitor.sv
tb_ddr3_wr_top.sv

/* tb_ddr3_wr_top.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_ddr3_wr_top;

	import ddr3_wr_pkg::*;

	localparam int CLK_PERIOD = 10;
	localparam int RESET_CYCLES = 8;
	localparam logic [31:0] LFSR_SEED = 32'ha617_75fb;

	typedef struct packed {
		logic [7:0] burst; // beats in AFI cycles
		logic [7:0] gap; // idle cycles after the burst
		logic [WR_SHIFT_WIDTH-1:0] shift;
		logic [AFI_DQS_WIDTH-1:0] oct_off;
		logic [AFI_DATA_MASK_WIDTH-1:0] be;
	} test_row_t;

	localparam int NUM_ROWS = 9;
	localparam test_row_t TEST_ROWS [NUM_ROWS] = '{
		'{8'd0, 8'd6, 2'd0, 2'b00, 4'hf}, // idle after reset
		'{8'd1, 8'd8, 2'd0, 2'b00, 4'hf},
		'{8'd2, 8'd8, 2'd0, 2'b00, 4'h5},
		'{8'd4, 8'd10, 2'd1, 2'b00, 4'ha},
		'{8'd4, 8'd10, 2'd2, 2'b01, 4'h3},
		'{8'd2, 8'd10, 2'd3, 2'b10, 4'hc},
		'{8'd1, 8'd10, 2'd3, 2'b11, 4'he},
		'{8'd4, 8'd12, 2'd0, 2'b01, 4'h7},
		'{8'd3, 8'd9, 2'd1, 2'b00, 4'h6}
	};

	logic pll_afi_clk;
	logic rst_n;
	logic wr_valid;
	logic [AFI_DATA_WIDTH-1:0] wr_data;
	logic [AFI_DATA_MASK_WIDTH-1:0] wr_be;
	logic [AFI_DQS_WIDTH-1:0] force_oct_off;
	logic [WR_SHIFT_WIDTH-1:0] wr_shift;
	phy_wr_t phy_wr;
	int error_count;
	int check_count;
	logic [31:0] lfsr_state;

	ddr3_wr_top dut0 (
		.pll_afi_clk   (pll_afi_clk),
		.rst_n         (rst_n),
		.wr_valid      (wr_valid),
		.wr_data       (wr_data),
		.wr_be         (wr_be),
		.force_oct_off (force_oct_off),
		.wr_shift      (wr_shift),
		.phy_wr        (phy_wr)
	);

	tb_wr_monitor mon0 (
		.pll_afi_clk   (pll_afi_clk),
		.rst_n         (rst_n),
		.wr_valid      (wr_valid),
		.wr_data       (wr_data),
		.wr_be         (wr_be),
		.force_oct_off (force_oct_off),
		.wr_shift      (wr_shift),
		.phy_wr        (phy_wr),
		.error_count   (error_count),
		.check_count   (check_count)
	);

	always #(CLK_PERIOD / 2) pll_afi_clk = ~pll_afi_clk;

	// x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] state);
		logic feedback;
		feedback = state[31] ^ state[21] ^ state[1] ^ state[0];
		return {state[30:0], feedback};
	endfunction

	task automatic draw_data_word(output logic [AFI_DATA_WIDTH-1:0] word);
		for (int b = 0; b < AFI_DATA_WIDTH; b++)
		begin
			lfsr_state = lfsr_step(lfsr_state);
			word[b] = lfsr_state[0];
		end
	endtask

	task automatic run_row(input test_row_t row);
		logic [AFI_DATA_WIDTH-1:0] word;
		for (int c = 0; c < row.burst + row.gap; c++)
		begin
			@(posedge pll_afi_clk);
			wr_shift <= row.shift; // only moves while the previous row has drained
			force_oct_off <= row.oct_off;
			if (c < row.burst)
			begin
				draw_data_word(word);
				wr_valid <= 1'b1;
				wr_data <= word;
				wr_be <= row.be;
			end
			else
			begin
				wr_valid <= 1'b0;
			end
		end
	endtask

	initial
	begin : watchdog
		int limit_cycles;
		limit_cycles = RESET_CYCLES + 20;
		for (int i = 0; i < NUM_ROWS; i++)
			limit_cycles += TEST_ROWS[i].burst + TEST_ROWS[i].gap;
		#(limit_cycles * CLK_PERIOD);
		$display("watchdog expired after %0d cycles before the test rows finished", limit_cycles);
		$display("Test FAILED");
		$finish;
	end

	initial
	begin : stimulus
		int errors_before;
		int row_errors;
		int rows_failed;
		pll_afi_clk = 1'b0;
		rst_n = 1'b0;
		wr_valid = 1'b0;
		wr_data = '0;
		wr_be = '0;
		force_oct_off = '0;
		wr_shift = '0;
		lfsr_state = LFSR_SEED;
		errors_before = 0;
		rows_failed = 0;
		repeat (RESET_CYCLES) @(posedge pll_afi_clk);
		rst_n <= 1'b1;
		for (int r = 0; r < NUM_ROWS; r++)
		begin
			run_row(TEST_ROWS[r]);
			@(negedge pll_afi_clk); // counters have settled for the last edge
			row_errors = error_count - errors_before;
			errors_before = error_count;
			if (row_errors != 0)
				rows_failed++;
			$display("row %0d burst=%0d gap=%0d shift=%0d oct_off=%b be=%h errors=%0d %s",
				r, TEST_ROWS[r].burst, TEST_ROWS[r].gap, TEST_ROWS[r].shift,
				TEST_ROWS[r].oct_off, TEST_ROWS[r].be, row_errors,
				(row_errors == 0) ? "pass" : "fail");
		end
		if (check_count == 0)
			$display("no output comparisons were made");
		$display("rows %0d, rows failed %0d, checks %0d, errors %0d",
			NUM_ROWS, rows_failed, check_count, error_count);
		if (error_count == 0 && check_count > 0)
		begin
			$display("Test OK");
		end
		else
		begin
			$display("Test FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* tb_wr_monitor.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_wr_monitor (
	input wire pll_afi_clk,
	input wire rst_n,
	input wire wr_valid,
	input wire [ddr3_wr_pkg::AFI_DATA_WIDTH-1:0] wr_data,
	input wire [ddr3_wr_pkg::AFI_DATA_MASK_WIDTH-1:0] wr_be,
	input wire [ddr3_wr_pkg::AFI_DQS_WIDTH-1:0] force_oct_off,
	input wire [ddr3_wr_pkg::WR_SHIFT_WIDTH-1:0] wr_shift,
	input wire ddr3_wr_pkg::phy_wr_t phy_wr,
	output int error_count,
	output int check_count
);

	import ddr3_wr_pkg::*;

	localparam int HIST_DEPTH = MAX_WR_SHIFT + 5; // oldest input needed is 4 + shift cycles back

	typedef struct packed {
		logic valid;
		logic [AFI_DATA_WIDTH-1:0] data;
		logic [AFI_DATA_MASK_WIDTH-1:0] be;
		logic [AFI_DQS_WIDTH-1:0] oct_off;
	} in_sample_t;

	in_sample_t hist [HIST_DEPTH]; // hist[a] holds the inputs seen a edges ago
	int errors = 0;
	int checks = 0;

	assign error_count = errors;
	assign check_count = checks;

	// expected output word for a given shift, from the decode, datapath and shift rules
	function automatic phy_wr_t predict_output(input int s);
		phy_wr_t expected;
		logic dqs_now;
		logic dqs_prev;
		dqs_now = hist[s+2].valid | hist[s+3].valid; // preamble cycle plus the data cycles
		dqs_prev = hist[s+3].valid | hist[s+4].valid;
		expected.dq = hist[s+3].data;
		expected.wrdata_mask = ~hist[s+3].be;
		expected.dqs_en = {AFI_DQS_WIDTH{dqs_now}};
		expected.wrdata_en = {AFI_DQS_WIDTH{hist[s+3].valid}};
		expected.oct_ena[AFI_DQS_WIDTH-1:MEM_WRITE_DQS_WIDTH] = {MEM_WRITE_DQS_WIDTH{~dqs_now}};
		expected.oct_ena[MEM_WRITE_DQS_WIDTH-1:0] =
			{MEM_WRITE_DQS_WIDTH{~(dqs_now | dqs_prev)}};
		expected.oct_ena = expected.oct_ena & ~hist[s].oct_off; // force-off travels with the word
		return expected;
	endfunction

	task automatic check_field(input string name, input logic [63:0] expected,
		input logic [63:0] actual);
		checks++;
		if (actual !== expected)
		begin
			errors++;
			$display("[ERROR] %0t ns phy_wr.%s expected 0x%0h actual 0x%0h",
				$time, name, expected, actual);
		end
	endtask

	task automatic compare_output(input int s);
		phy_wr_t expected;
		expected = predict_output(s);
		check_field("dqs_en", expected.dqs_en, phy_wr.dqs_en);
		check_field("wrdata_en", expected.wrdata_en, phy_wr.wrdata_en);
		check_field("oct_ena", expected.oct_ena, phy_wr.oct_ena);
		// data registers are free running, only beats carry meaning
		if (expected.wrdata_en[0])
		begin
			check_field("dq", expected.dq, phy_wr.dq);
			check_field("wrdata_mask", expected.wrdata_mask, phy_wr.wrdata_mask);
		end
	endtask

	always @(posedge pll_afi_clk)
	begin : sample_and_check
		in_sample_t smp;
		smp.valid = rst_n & wr_valid; // the decode holds valid low through reset
		smp.data = wr_data;
		smp.be = wr_be;
		smp.oct_off = force_oct_off;
		for (int a = HIST_DEPTH - 1; a > 0; a--)
			hist[a] = hist[a-1];
		hist[0] = smp;
		if (rst_n)
			compare_output(int'(wr_shift));
	end

endmodule

`default_nettype wire

/* ddr3_wr_top.sv */
`timescale 1ns/100ps
`default_nettype none

module ddr3_wr_top (
	input wire pll_afi_clk,
	input wire rst_n,
	input wire wr_valid,
	input wire [ddr3_wr_pkg::AFI_DATA_WIDTH-1:0] wr_data,
	input wire [ddr3_wr_pkg::AFI_DATA_MASK_WIDTH-1:0] wr_be,
	input wire [ddr3_wr_pkg::AFI_DQS_WIDTH-1:0] force_oct_off,
	input wire [ddr3_wr_pkg::WR_SHIFT_WIDTH-1:0] wr_shift,
	output ddr3_wr_pkg::phy_wr_t phy_wr
);

	import ddr3_wr_pkg::*;

	wire afi_wr_t afi_wr;
	wire phy_wr_t phy_pre; // datapath output before write-latency shift

	wr_burst_decode decode0 (
		.pll_afi_clk (pll_afi_clk),
		.rst_n       (rst_n),
		.wr_valid    (wr_valid),
		.wr_data     (wr_data),
		.wr_be       (wr_be),
		.afi_wr      (afi_wr)
	);

	ddr3_write_datapath datapath0 (
		.pll_afi_clk   (pll_afi_clk),
		.rst_n         (rst_n),
		.afi_wr        (afi_wr),
		.force_oct_off (force_oct_off),
		.phy_pre       (phy_pre)
	);

	// wr_shift is only changed while no write is in flight
	ddr3_write_shift shift0 (
		.pll_afi_clk (pll_afi_clk),
		.rst_n       (rst_n),
		.wr_shift    (wr_shift),
		.phy_pre     (phy_pre),
		.phy_wr      (phy_wr)
	);

endmodule

`default_nettype wire

/* ddr3_write_shift.sv */
`timescale 1ns/100ps
`default_nettype none

module ddr3_write_shift (
	input wire pll_afi_clk,
	input wire rst_n,
	input wire [ddr3_wr_pkg::WR_SHIFT_WIDTH-1:0] wr_shift,
	input wire ddr3_wr_pkg::phy_wr_t phy_pre,
	output ddr3_wr_pkg::phy_wr_t phy_wr
);

	import ddr3_wr_pkg::*;

	phy_wr_t ladder [1:MAX_WR_SHIFT]; // ladder[n] is phy_pre delayed by n cycles

	always_ff @(posedge pll_afi_clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			for (int i = 1; i <= MAX_WR_SHIFT; i++)
				ladder[i] <= PHY_WR_IDLE;
		end
		else
		begin
			ladder[1] <= phy_pre;
			for (int i = 2; i <= MAX_WR_SHIFT; i++)
				ladder[i] <= ladder[i-1];
		end
	end

	// whole bundle moves together so the write stays aligned with its termination
	always_comb
	begin
		if (wr_shift == '0)
		begin
			phy_wr = phy_pre;
		end
		else
		begin
			phy_wr = ladder[wr_shift];
		end
	end

endmodule

`default_nettype wire

/* ddr3_write_datapath.sv */
`timescale 1ns/100ps
`default_nettype none

module ddr3_write_datapath (
	input wire pll_afi_clk,
	input wire rst_n,
	input wire ddr3_wr_pkg::afi_wr_t afi_wr,
	input wire [ddr3_wr_pkg::AFI_DQS_WIDTH-1:0] force_oct_off,
	output ddr3_wr_pkg::phy_wr_t phy_pre
);

	import ddr3_wr_pkg::*;

	logic [AFI_DQS_WIDTH-1:0] dqs_en_out;
	logic [AFI_DQS_WIDTH-1:0] wrdata_en_out;
	logic [AFI_DATA_WIDTH-1:0] dq_out;
	logic [AFI_DATA_MASK_WIDTH-1:0] mask_out;
	logic [MEM_WRITE_DQS_WIDTH-1:0] dqs_en_hi_r;
	logic [AFI_DQS_WIDTH-1:0] oct_ena;

	generate
		if (NUM_WRITE_PATH_FLOP_STAGES == 0)
		begin : g_bypass
			assign dqs_en_out = afi_wr.dqs_en;
			assign wrdata_en_out = afi_wr.wdata_valid;
			assign dq_out = afi_wr.wdata;
			assign mask_out = afi_wr.dm;
		end
		else
		begin : g_pipe
			logic [AFI_DQS_WIDTH-1:0] dqs_en_r [NUM_WRITE_PATH_FLOP_STAGES];
			logic [AFI_DQS_WIDTH-1:0] valid_r [NUM_WRITE_PATH_FLOP_STAGES];
			logic [AFI_DATA_WIDTH-1:0] wdata_r [NUM_WRITE_PATH_FLOP_STAGES];
			logic [AFI_DATA_MASK_WIDTH-1:0] dm_r [NUM_WRITE_PATH_FLOP_STAGES];

			for (genvar s = 0; s < NUM_WRITE_PATH_FLOP_STAGES; s++)
			begin : g_stage
				logic [AFI_DQS_WIDTH-1:0] dqs_en_d;
				logic [AFI_DQS_WIDTH-1:0] valid_d;
				logic [AFI_DATA_WIDTH-1:0] wdata_d;
				logic [AFI_DATA_MASK_WIDTH-1:0] dm_d;

				if (s == 0)
				begin : g_src
					assign dqs_en_d = afi_wr.dqs_en;
					assign valid_d = afi_wr.wdata_valid;
					assign wdata_d = afi_wr.wdata;
					assign dm_d = afi_wr.dm;
				end
				else
				begin : g_src
					assign dqs_en_d = dqs_en_r[s-1];
					assign valid_d = valid_r[s-1];
					assign wdata_d = wdata_r[s-1];
					assign dm_d = dm_r[s-1];
				end

				// enables must come out of reset low
				always_ff @(posedge pll_afi_clk or negedge rst_n)
				begin
					if (!rst_n)
					begin
						dqs_en_r[s] <= '0;
						valid_r[s] <= '0;
					end
					else
					begin
						dqs_en_r[s] <= dqs_en_d;
						valid_r[s] <= valid_d;
					end
				end

				always_ff @(posedge pll_afi_clk)
				begin
					wdata_r[s] <= wdata_d;
					dm_r[s] <= dm_d;
				end
			end

			assign dqs_en_out = dqs_en_r[NUM_WRITE_PATH_FLOP_STAGES-1];
			assign wrdata_en_out = valid_r[NUM_WRITE_PATH_FLOP_STAGES-1];
			assign dq_out = wdata_r[NUM_WRITE_PATH_FLOP_STAGES-1];
			assign mask_out = dm_r[NUM_WRITE_PATH_FLOP_STAGES-1];
		end
	endgenerate

	// previous upper dqs_en keeps termination off one half-cycle past the burst
	always_ff @(posedge pll_afi_clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			dqs_en_hi_r <= '0;
		end
		else
		begin
			dqs_en_hi_r <= dqs_en_out[AFI_DQS_WIDTH-1:MEM_WRITE_DQS_WIDTH];
		end
	end

	assign oct_ena[AFI_DQS_WIDTH-1:MEM_WRITE_DQS_WIDTH] =
		~dqs_en_out[AFI_DQS_WIDTH-1:MEM_WRITE_DQS_WIDTH];
	assign oct_ena[MEM_WRITE_DQS_WIDTH-1:0] =
		~(dqs_en_out[AFI_DQS_WIDTH-1:MEM_WRITE_DQS_WIDTH] | dqs_en_hi_r);

	always_comb
	begin
		phy_pre.dq = dq_out;
		phy_pre.dqs_en = dqs_en_out;
		phy_pre.wrdata_en = wrdata_en_out;
		phy_pre.wrdata_mask = mask_out;
		phy_pre.oct_ena = oct_ena & ~force_oct_off; // forced groups never terminate
	end

endmodule

`default_nettype wire

/* wr_burst_decode.sv */
`timescale 1ns/100ps
`default_nettype none

module wr_burst_decode (
	input wire pll_afi_clk,
	input wire rst_n,
	input wire wr_valid,
	input wire [ddr3_wr_pkg::AFI_DATA_WIDTH-1:0] wr_data,
	input wire [ddr3_wr_pkg::AFI_DATA_MASK_WIDTH-1:0] wr_be,
	output ddr3_wr_pkg::afi_wr_t afi_wr
);

	import ddr3_wr_pkg::*;

	logic wr_valid_r;
	logic [AFI_DATA_WIDTH-1:0] wdata_r;
	logic [AFI_DATA_MASK_WIDTH-1:0] dm_r;
	logic dqs_open;

	// beat valid, delayed to line up with the registered data
	always_ff @(posedge pll_afi_clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			wr_valid_r <= 1'b0;
		end
		else
		begin
			wr_valid_r <= wr_valid;
		end
	end

	always_ff @(posedge pll_afi_clk)
	begin
		wdata_r <= wr_data;
		dm_r <= ~wr_be; // a mask bit blocks its byte
	end

	// the incoming beat opens DQS a cycle before its data, the registered one holds it
	assign dqs_open = wr_valid | wr_valid_r;

	always_comb
	begin
		afi_wr.dqs_en = {AFI_DQS_WIDTH{dqs_open}};
		afi_wr.wdata_valid = {AFI_DQS_WIDTH{wr_valid_r}};
		afi_wr.wdata = wdata_r;
		afi_wr.dm = dm_r;
	end

endmodule

`default_nettype wire

/* ddr3_wr_pkg.sv */
`default_nettype none

package ddr3_wr_pkg;

	// memory side of the write path
	localparam int MEM_DQ_WIDTH = 8;
	localparam int MEM_WRITE_DQS_WIDTH = 1;

	// half-rate AFI word carries four memory beats per clock
	localparam int AFI_BEATS = 4;
	localparam int AFI_DQS_WIDTH = 2 * MEM_WRITE_DQS_WIDTH; // upper half is the later half-cycle
	localparam int AFI_DATA_WIDTH = AFI_BEATS * MEM_DQ_WIDTH;
	localparam int AFI_DATA_MASK_WIDTH = AFI_BEATS;

	// pipeline depths
	localparam int NUM_WRITE_PATH_FLOP_STAGES = 2;
	localparam int MAX_WR_SHIFT = 3;
	localparam int WR_SHIFT_WIDTH = $clog2(MAX_WR_SHIFT + 1);

	// controller-side write word
	typedef struct packed {
		logic [AFI_DQS_WIDTH-1:0] dqs_en;
		logic [AFI_DQS_WIDTH-1:0] wdata_valid;
		logic [AFI_DATA_WIDTH-1:0] wdata;
		logic [AFI_DATA_MASK_WIDTH-1:0] dm;
	} afi_wr_t;

	// DDIO-side write word
	typedef struct packed {
		logic [AFI_DATA_WIDTH-1:0] dq;
		logic [AFI_DQS_WIDTH-1:0] dqs_en;
		logic [AFI_DQS_WIDTH-1:0] wrdata_en;
		logic [AFI_DATA_MASK_WIDTH-1:0] wrdata_mask;
		logic [AFI_DQS_WIDTH-1:0] oct_ena;
	} phy_wr_t;

	// what the output looks like with no write in flight
	localparam phy_wr_t PHY_WR_IDLE = '{
		dq: '0,
		dqs_en: '0,
		wrdata_en: '0,
		wrdata_mask: '0,
		oct_ena: '1
	};

endpackage

`default_nettype wire
